/* compile.f */
design/router_pkt_pkg.sv
design/router_cfg_pkg.sv
design/port_fifo.sv
design/idle_watchdog.sv
design/parity_checker.sv
design/packet_control.sv
design/packet_router.sv
tests/router_checker.sv
tests/tb_packet_router.sv

/* design/idle_watchdog.sv */
// Idle watchdog that flushes a port whose reader leaves valid data unread for too long
`timescale 1ns/1ns

module idle_watchdog
  import router_cfg_pkg::*;
#(
  parameter int IDLE_LIMIT = DEFAULT_IDLE_LIMIT
)
(
  input  logic clock,
  input  logic resetn,
  input  logic valid_out,
  input  logic read_enb,
  output logic flush
);

  localparam int CNT_W = $clog2(IDLE_LIMIT);

  logic [CNT_W-1:0] idle_cnt;
  logic             stalled;

  assign stalled = valid_out && !read_enb;

  // Fires on the IDLE_LIMIT-th stalled cycle in a row
  assign flush = stalled && (idle_cnt == CNT_W'(IDLE_LIMIT - 1));

  always_ff @(posedge clock)
  begin
    if (!resetn)
      idle_cnt <= '0;
    else if (!stalled || flush)
      idle_cnt <= '0;
    else
      idle_cnt <= idle_cnt + 1'b1;
  end

  // Flushed port shows no data on the next cycle
  a_empty_after_flush: assert property (@(posedge clock) disable iff (!resetn)
    flush |=> !valid_out);

endmodule

/* design/packet_control.sv */
// Packet control: decodes the header, steers each byte to its port FIFO and drives busy
`timescale 1ns/1ns

module packet_control
  import router_pkt_pkg::*;
  import router_cfg_pkg::*;
(
  input  logic                 clock,
  input  logic                 resetn,
  input  data_byte_t           data_in,
  input  logic                 pkt_valid,
  input  logic [NUM_PORTS-1:0] fifo_empty,
  input  logic [NUM_PORTS-1:0] fifo_full,
  input  logic [NUM_PORTS-1:0] flush,
  output logic                 busy,
  output logic [NUM_PORTS-1:0] write_enb,
  output data_byte_t           write_data,
  output logic                 hdr_accept,
  output logic                 payload_accept,
  output logic                 parity_accept
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_EMPTY,
    ST_LOAD,
    ST_DISCARD
  } state_t;

  state_t     state;
  state_t     state_next;
  header_t    hdr_in;
  header_t    hdr_held;
  port_code_t target;
  port_code_t write_port;
  pkt_len_t   remaining;
  logic       write_req;

  assign hdr_in = header_t'(data_in);

  always_comb
  begin
    state_next     = state;
    busy           = 1'b0;
    write_req      = 1'b0;
    write_port     = target;
    write_data     = data_in;
    hdr_accept     = 1'b0;
    payload_accept = 1'b0;
    parity_accept  = 1'b0;
    case (state)
      ST_IDLE:
        if (pkt_valid)
        begin
          if (hdr_in.fields.dest == PORT_DISCARD)
            state_next = ST_DISCARD;
          else
          begin
            hdr_accept = 1'b1;
            // Header goes straight in only when the port has drained
            if (fifo_empty[hdr_in.fields.dest])
            begin
              write_req  = 1'b1;
              write_port = hdr_in.fields.dest;
              state_next = ST_LOAD;
            end
            else
              state_next = ST_WAIT_EMPTY;
          end
        end
      ST_WAIT_EMPTY:
      begin
        busy       = 1'b1;
        write_data = hdr_held.raw;
        if (fifo_empty[target])
        begin
          write_req  = 1'b1;
          state_next = ST_LOAD;
        end
      end
      ST_LOAD:
      begin
        busy = fifo_full[target];
        // Port flushed under us, drop the rest of the packet
        if (flush[target])
          state_next = ST_DISCARD;
        else if (pkt_valid && !fifo_full[target])
        begin
          write_req = 1'b1;
          if (remaining == '0)
          begin
            parity_accept = 1'b1;
            state_next    = ST_IDLE;
          end
          else
            payload_accept = 1'b1;
        end
      end
      ST_DISCARD:
        if (!pkt_valid)
          state_next = ST_IDLE;
      default:
        state_next = ST_IDLE;
    endcase
  end

  always_comb
  begin
    for (int i = 0; i < NUM_PORTS; i++)
      write_enb[i] = write_req && (write_port == port_code_t'(i));
  end

  always_ff @(posedge clock)
  begin
    if (!resetn)
      state <= ST_IDLE;
    else
      state <= state_next;
  end

  // Target, held header and byte count of the packet in flight
  always_ff @(posedge clock)
  begin
    if (hdr_accept)
    begin
      target    <= hdr_in.fields.dest;
      remaining <= hdr_in.fields.length;
      hdr_held  <= hdr_in;
    end
    else if (payload_accept)
      remaining <= remaining - 1'b1;
  end

  // One port at a time, and never into a FIFO that reports full
  a_write_onehot: assert property (@(posedge clock) disable iff (!resetn)
    $onehot0(write_enb) && ((write_enb & fifo_full) == '0));

endmodule

/* design/packet_router.sv */
// Packet router top: one byte input steered into three output FIFOs with idle flush
`timescale 1ns/1ns

module packet_router
  import router_pkt_pkg::*;
  import router_cfg_pkg::*;
#(
  parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH,
  parameter int IDLE_LIMIT = DEFAULT_IDLE_LIMIT
)
(
  input  logic       clock,
  input  logic       resetn,
  input  data_byte_t data_in,
  input  logic       pkt_valid,
  input  logic       read_enb_0,
  input  logic       read_enb_1,
  input  logic       read_enb_2,
  output data_byte_t data_out_0,
  output data_byte_t data_out_1,
  output data_byte_t data_out_2,
  output logic       valid_out_0,
  output logic       valid_out_1,
  output logic       valid_out_2,
  output logic       busy,
  output logic       error
);

  logic [NUM_PORTS-1:0] write_enb;
  data_byte_t           write_data;
  logic [NUM_PORTS-1:0] fifo_empty;
  logic [NUM_PORTS-1:0] fifo_full;
  logic [NUM_PORTS-1:0] flush;
  logic [NUM_PORTS-1:0] port_valid;
  logic [NUM_PORTS-1:0] port_read;
  data_byte_t           port_data [NUM_PORTS];
  logic                 hdr_accept;
  logic                 payload_accept;
  logic                 parity_accept;

  assign port_read = {read_enb_2, read_enb_1, read_enb_0};

  assign data_out_0  = port_data[0];
  assign data_out_1  = port_data[1];
  assign data_out_2  = port_data[2];
  assign valid_out_0 = port_valid[0];
  assign valid_out_1 = port_valid[1];
  assign valid_out_2 = port_valid[2];

  packet_control packet_control_inst (
    .clock          (clock),
    .resetn         (resetn),
    .data_in        (data_in),
    .pkt_valid      (pkt_valid),
    .fifo_empty     (fifo_empty),
    .fifo_full      (fifo_full),
    .flush          (flush),
    .busy           (busy),
    .write_enb      (write_enb),
    .write_data     (write_data),
    .hdr_accept     (hdr_accept),
    .payload_accept (payload_accept),
    .parity_accept  (parity_accept)
  );

  parity_checker parity_checker_inst (
    .clock          (clock),
    .resetn         (resetn),
    .data_in        (data_in),
    .hdr_accept     (hdr_accept),
    .payload_accept (payload_accept),
    .parity_accept  (parity_accept),
    .error          (error)
  );

  // One FIFO and one watchdog per output port
  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_port
    port_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) port_fifo_inst (
      .clock      (clock),
      .resetn     (resetn),
      .flush      (flush[i]),
      .write_enb  (write_enb[i]),
      .write_data (write_data),
      .read_enb   (port_read[i]),
      .data_out   (port_data[i]),
      .valid_out  (port_valid[i]),
      .empty      (fifo_empty[i]),
      .full       (fifo_full[i])
    );

    idle_watchdog #(
      .IDLE_LIMIT (IDLE_LIMIT)
    ) idle_watchdog_inst (
      .clock     (clock),
      .resetn    (resetn),
      .valid_out (port_valid[i]),
      .read_enb  (port_read[i]),
      .flush     (flush[i])
    );
  end

endmodule

/* design/parity_checker.sv */
// Parity checker: XOR of header and payload compared against the trailing parity byte
`timescale 1ns/1ns

module parity_checker
  import router_pkt_pkg::*;
(
  input  logic       clock,
  input  logic       resetn,
  input  data_byte_t data_in,
  input  logic       hdr_accept,
  input  logic       payload_accept,
  input  logic       parity_accept,
  output logic       error
);

  data_byte_t parity_acc;

  // Running XOR, restarted by each header
  always_ff @(posedge clock)
  begin
    if (hdr_accept)
      parity_acc <= data_in;
    else if (payload_accept)
      parity_acc <= parity_acc ^ data_in;
  end

  // Result holds until the next header is taken
  always_ff @(posedge clock)
  begin
    if (!resetn)
      error <= 1'b0;
    else if (hdr_accept)
      error <= 1'b0;
    else if (parity_accept)
      error <= (parity_acc != data_in);
  end

  // A header always comes before the parity byte it is checked against
  a_parity_after_header: assert property (@(posedge clock) disable iff (!resetn)
    hdr_accept |=> !parity_accept);

endmodule

/* design/port_fifo.sv */
// Show-ahead synchronous byte FIFO that buffers one output port and clears on flush
`timescale 1ns/1ns

module port_fifo
  import router_pkt_pkg::*;
  import router_cfg_pkg::*;
#(
  parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
)
(
  input  logic       clock,
  input  logic       resetn,
  input  logic       flush,
  input  logic       write_enb,
  input  data_byte_t write_data,
  input  logic       read_enb,
  output data_byte_t data_out,
  output logic       valid_out,
  output logic       empty,
  output logic       full
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  data_byte_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign empty     = (count == '0);
  assign full      = (count == (PTR_W + 1)'(FIFO_DEPTH));
  assign valid_out = !empty;
  assign data_out  = mem[rd_ptr];

  assign push = write_enb && !full;
  assign pop  = read_enb && !empty;

  always_ff @(posedge clock)
  begin
    if (push)
      mem[wr_ptr] <= write_data;
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clock)
  begin
    if (!resetn || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Control must hold off writes to a full port
  a_no_overflow: assert property (@(posedge clock) disable iff (!resetn)
    !(write_enb && full));

endmodule

/* design/router_cfg_pkg.sv */
// Router configuration constants: port count and default FIFO and watchdog sizing
package router_cfg_pkg;

  // Output ports served by the router
  localparam int NUM_PORTS = 3;

  // Bytes held per port FIFO, a power of two
  localparam int DEFAULT_FIFO_DEPTH = 16;

  // Stalled cycles before a port is flushed
  localparam int DEFAULT_IDLE_LIMIT = 30;

endpackage

/* design/router_pkt_pkg.sv */
// Packet format types shared by the router: bus byte, port code and header layout
package router_pkt_pkg;

  typedef logic [7:0] data_byte_t;

  // Destination code, ports 0 to 2 plus the discard code
  typedef logic [1:0] port_code_t;

  // Payload byte count carried in the header
  typedef logic [5:0] pkt_len_t;

  localparam port_code_t PORT_DISCARD = 2'd3;

  typedef struct packed {
    pkt_len_t   length;
    port_code_t dest;
  } header_fields_t;

  // Same byte seen as raw data for parity or as decoded fields
  typedef union packed {
    data_byte_t     raw;
    header_fields_t fields;
  } header_t;

endpackage

/* tests/router_checker.sv */
// Router checker: compares bytes leaving each port, the error flag and busy against expectations
`timescale 1ns/1ns

module router_checker
  import router_pkt_pkg::*;
  import router_cfg_pkg::*;
(
  input logic       clock,
  input logic       resetn,
  input data_byte_t data_out_0,
  input data_byte_t data_out_1,
  input data_byte_t data_out_2,
  input logic       valid_out_0,
  input logic       valid_out_1,
  input logic       valid_out_2,
  input logic       read_enb_0,
  input logic       read_enb_1,
  input logic       read_enb_2,
  input logic       busy,
  input logic       error
);

  // Expected bytes in send order, port code in the top two bits
  logic [9:0] exp_q [$];

  // Loaded by the driver just before it triggers an event
  logic [1:0] ev_port;
  data_byte_t ev_byte;
  logic       ev_error;
  event       byte_sent;
  event       parity_done;

  string test_name = "reset";
  logic  busy_seen = 1'b0;
  int    test_errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    total_errors = 0;

  task automatic value_error(input string what, input logic [7:0] expected,
                             input logic [7:0] actual);
    $display("error: test %s, %s expected %h actual %h", test_name, what, expected, actual);
    test_errors++;
  endtask

  task automatic report_failure(input string what);
    $display("test %s: %s", test_name, what);
    test_errors++;
  endtask

  // Oldest byte still owed to a port, -1 when nothing is owed
  function automatic int take_expected(input int port);
    int i;
    take_expected = -1;
    for (i = 0; i < exp_q.size(); i++)
    begin
      if (exp_q[i][9:8] == port)
      begin
        take_expected = int'(exp_q[i][7:0]);
        exp_q.delete(i);
        break;
      end
    end
  endfunction

  task automatic check_byte(input int port, input data_byte_t actual);
    int expected;
    expected = take_expected(port);
    if (expected < 0)
      report_failure($sformatf("byte %h came out of port %0d unexpectedly", actual, port));
    else if (data_byte_t'(expected) !== actual)
      value_error($sformatf("port %0d byte", port), data_byte_t'(expected), actual);
  endtask

  task automatic check_busy(input logic expected);
    if (busy_seen !== expected)
      value_error("busy seen", expected, busy_seen);
  endtask

  task automatic finish_test();
    if (exp_q.size() != 0)
    begin
      report_failure($sformatf("%0d expected bytes never came out", exp_q.size()));
      exp_q.delete();
    end
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0)
      $display("%s: pass", test_name);
    else
    begin
      $display("%s: %0d errors", test_name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  always @(byte_sent)
    exp_q.push_back({ev_port, ev_byte});

  // Parity result is already registered when the driver signals
  always @(parity_done)
    if (error !== ev_error)
      value_error("error flag", ev_error, error);

  always @(posedge clock)
  begin
    if (resetn)
    begin
      if (busy)
        busy_seen = 1'b1;
      if (valid_out_0 && read_enb_0)
        check_byte(0, data_out_0);
      if (valid_out_1 && read_enb_1)
        check_byte(1, data_out_1);
      if (valid_out_2 && read_enb_2)
        check_byte(2, data_out_2);
    end
  end

endmodule

/* tests/router_testdata.txt */
// name dest length corrupt stall count
// corrupt 1 inverts the parity byte, stall is reader hold-off in cycles, count is packets sent
routing_p0 0 8 0 0 1
routing_p1 1 1 0 0 1
routing_p2 2 63 0 0 1
parity_error 1 12 1 0 1
discard 3 20 0 0 1
routing_after_discard 0 3 0 0 1
back_pressure 0 30 0 24 1
wait_empty 1 10 0 20 2
idle_flush 2 5 0 45 1
after_flush 2 7 1 0 1
flush_abort 1 40 1 60 1
after_abort 1 9 0 3 1
discard_short 3 1 0 0 1

/* tests/tb_packet_router.sv */
// Packet router testbench: replays packets from the test data file and runs the port readers
`timescale 1ns/1ns

module tb_packet_router
  import router_pkt_pkg::*;
  import router_cfg_pkg::*;
();

  localparam int FIFO_DEPTH = DEFAULT_FIFO_DEPTH;
  localparam int IDLE_LIMIT = DEFAULT_IDLE_LIMIT;
  localparam int TIMEOUT = 2000;

  logic                 clock;
  logic                 resetn;
  data_byte_t           data_in;
  logic                 pkt_valid;
  logic [NUM_PORTS-1:0] read_enb;
  wire data_byte_t      data_out_0;
  wire data_byte_t      data_out_1;
  wire data_byte_t      data_out_2;
  wire [NUM_PORTS-1:0]  valid_out;
  wire                  busy;
  wire                  error;

  int          stall_left [NUM_PORTS];
  logic [31:0] lcg_state;
  logic        exp_error;

  packet_router #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .IDLE_LIMIT (IDLE_LIMIT)
  ) packet_router_inst (
    .clock       (clock),
    .resetn      (resetn),
    .data_in     (data_in),
    .pkt_valid   (pkt_valid),
    .read_enb_0  (read_enb[0]),
    .read_enb_1  (read_enb[1]),
    .read_enb_2  (read_enb[2]),
    .data_out_0  (data_out_0),
    .data_out_1  (data_out_1),
    .data_out_2  (data_out_2),
    .valid_out_0 (valid_out[0]),
    .valid_out_1 (valid_out[1]),
    .valid_out_2 (valid_out[2]),
    .busy        (busy),
    .error       (error)
  );

  router_checker router_checker_inst (
    .clock       (clock),
    .resetn      (resetn),
    .data_out_0  (data_out_0),
    .data_out_1  (data_out_1),
    .data_out_2  (data_out_2),
    .valid_out_0 (valid_out[0]),
    .valid_out_1 (valid_out[1]),
    .valid_out_2 (valid_out[2]),
    .read_enb_0  (read_enb[0]),
    .read_enb_1  (read_enb[1]),
    .read_enb_2  (read_enb[2]),
    .busy        (busy),
    .error       (error)
  );

  always #5 clock = ~clock;

  // Each reader holds off for its stall count, then reads every cycle
  always @(negedge clock)
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      read_enb[p] = (stall_left[p] == 0);
      if (stall_left[p] > 0)
        stall_left[p]--;
    end
  end

  function automatic data_byte_t next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic abort_run(input string why);
    $display("run stopped: %s", why);
    $display("Test failed");
    $finish;
  endtask

  // Drive one byte and hold it while busy is high
  task automatic send_byte(input data_byte_t value, input int port, input logic deliver);
    int waited;
    waited = 0;
    @(negedge clock);
    data_in   = value;
    pkt_valid = 1'b1;
    while (busy)
    begin
      @(negedge clock);
      waited++;
      if (waited > TIMEOUT)
        abort_run("busy stayed high");
    end
    if (deliver)
    begin
      router_checker_inst.ev_port = port;
      router_checker_inst.ev_byte = value;
      -> router_checker_inst.byte_sent;
    end
  endtask

  task automatic send_packet(input int dest, input int length, input int corrupt,
                             input logic deliver);
    data_byte_t header;
    data_byte_t payload;
    data_byte_t parity;
    int         i;
    header = data_byte_t'(length * 4 + dest);
    parity = header;
    send_byte(header, dest, deliver);
    for (i = 0; i < length; i++)
    begin
      payload = next_random();
      parity  = parity ^ payload;
      send_byte(payload, dest, deliver);
    end
    if (corrupt != 0)
      parity = ~parity;
    send_byte(parity, dest, deliver);
    @(negedge clock);
    pkt_valid = 1'b0;
  endtask

  // Ports drained and all readers past their stall
  function automatic logic ports_idle();
    ports_idle = (valid_out == '0);
    for (int p = 0; p < NUM_PORTS; p++)
      if (stall_left[p] != 0)
        ports_idle = 1'b0;
  endfunction

  task automatic run_test(input string name, input int dest, input int length,
                          input int corrupt, input int stall, input int count);
    logic flushed;
    logic aborted;
    logic deliver;
    logic exp_busy;
    int   k;
    int   waited;
    flushed  = (dest < NUM_PORTS) && (stall > IDLE_LIMIT);
    aborted  = flushed && (length + 2 > FIFO_DEPTH);
    deliver  = (dest < NUM_PORTS) && !flushed;
    exp_busy = (dest < NUM_PORTS) && ((count > 1 && stall > length + 4) ||
               (length + 2 > FIFO_DEPTH && stall > FIFO_DEPTH));
    @(posedge clock);
    if (dest < NUM_PORTS)
      stall_left[dest] = stall;
    @(negedge clock);
    router_checker_inst.test_name = name;
    router_checker_inst.busy_seen = 1'b0;
    for (k = 0; k < count; k++)
    begin
      send_packet(dest, length, corrupt, deliver);
      // A header clears error, and an aborted packet never reaches its parity byte
      if (dest < NUM_PORTS)
        exp_error = aborted ? 1'b0 : (corrupt != 0);
      router_checker_inst.ev_error = exp_error;
      -> router_checker_inst.parity_done;
    end
    if (flushed)
    begin
      waited = 0;
      @(posedge clock);
      while (valid_out[dest] && waited <= IDLE_LIMIT + 2)
      begin
        @(posedge clock);
        waited++;
      end
      if (valid_out[dest])
        router_checker_inst.report_failure("valid_out did not fall after the idle limit");
    end
    waited = 0;
    @(posedge clock);
    while (!ports_idle())
    begin
      @(posedge clock);
      waited++;
      if (waited > TIMEOUT)
        abort_run($sformatf("ports did not drain in test %s", name));
    end
    @(negedge clock);
    router_checker_inst.check_busy(exp_busy);
    router_checker_inst.finish_test();
  endtask

  initial
  begin
    int    fd;
    int    fields;
    string line;
    string name;
    int    dest;
    int    length;
    int    corrupt;
    int    stall;
    int    count;
    clock     = 1'b0;
    resetn    = 1'b0;
    data_in   = '0;
    pkt_valid = 1'b0;
    read_enb  = '0;
    exp_error = 1'b0;
    lcg_state = 32'h5eaf;
    for (int p = 0; p < NUM_PORTS; p++)
      stall_left[p] = 0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;
    fd = $fopen("tests/router_testdata.txt", "r");
    if (fd == 0)
      abort_run("cannot open tests/router_testdata.txt");
    while (!$feof(fd))
    begin
      line   = "";
      fields = $fgets(line, fd);
      if (line.len() < 2 || line.substr(0, 1) == "//")
        continue;
      fields = $sscanf(line, "%s %d %d %d %d %d", name, dest, length, corrupt, stall, count);
      if (fields == 6)
        run_test(name, dest, length, corrupt, stall, count);
      else
        router_checker_inst.report_failure($sformatf("bad test data line: %s", line));
    end
    $fclose(fd);
    $display("tests run %0d, tests with errors %0d, errors %0d",
             router_checker_inst.tests_run, router_checker_inst.tests_failed,
             router_checker_inst.total_errors + router_checker_inst.test_errors);
    if (router_checker_inst.tests_failed == 0 && router_checker_inst.test_errors == 0 &&
        router_checker_inst.tests_run > 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule
